//--- verilog/xy_motion_pkg.sv
`default_nettype none

// shared types and register map of the x/y positioning controller
package xy_motion_pkg;

  localparam int AXI_ADDR_WIDTH = 5;   // byte address into the register window
  localparam int AXI_DATA_WIDTH = 32;  // every register is one full word

  // sequencer states, encoded in the order the cycle runs through them
  typedef enum logic [2:0] {
    initialize1 = 3'b000,  // first cycle after reset, clears both axes
    initialize2 = 3'b001,  // settle cycle before the machine goes idle
    at_rest     = 3'b010,  // idle and waiting for a motion request
    capture_xy  = 3'b011,  // staged targets latched into the axis channels
    in_motion   = 3'b100,  // both axes step toward their targets
    xy_reached  = 3'b101   // one cycle that reports completion
  } seq_state_t;

  // AXI response codes used by this slave
  typedef enum logic [1:0] {
    okay   = 2'b00,
    slverr = 2'b10
  } axi_resp_t;

  // register byte offsets
  localparam logic [AXI_ADDR_WIDTH-1:0] ADDR_CTRL     = 5'h00;  // bit 0 written as one starts a move
  localparam logic [AXI_ADDR_WIDTH-1:0] ADDR_TARGET_X = 5'h04;  // staged target x
  localparam logic [AXI_ADDR_WIDTH-1:0] ADDR_TARGET_Y = 5'h08;  // staged target y
  localparam logic [AXI_ADDR_WIDTH-1:0] ADDR_POS      = 5'h0C;  // read only, y in 31:16 and x in 15:0
  localparam logic [AXI_ADDR_WIDTH-1:0] ADDR_STATUS   = 5'h10;  // read only, done in bit 1 and busy in bit 0

endpackage

`default_nettype wire

//--- verilog/axis_channel.sv
`timescale 1ns/1ps
`default_nettype none

// one axis of the controller
// it holds the captured target and the position counter and compares the two
module axis_channel #(
  parameter int COORD_WIDTH = 10  // bits in one coordinate
) (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   init,           // clears target and position
  input  wire                   capt_enbl,      // latches the staged target
  input  wire                   count_en,       // steps the position by one unit
  input  wire                   up1_dwn0,       // step direction, one counts up
  input  wire [COORD_WIDTH-1:0] target_staged,  // target as written by the host
  output logic [COORD_WIDTH-1:0] position,      // current position of this axis
  output logic                  comp_eq,        // position equals the captured target
  output logic                  comp_gt,        // position lies above the captured target
  output logic                  comp_lt         // position lies below the captured target
);

  logic [COORD_WIDTH-1:0] target_q;  // target captured at the start of a move
  logic [COORD_WIDTH-1:0] step_pos;  // position one unit in the requested direction

  // the captured target only changes on init or on a capture from the sequencer
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      target_q <= '0;  // comparators start from a known target
    end
    else if (init)
    begin
      target_q <= '0;  // the sequencer clears the axis once after reset
    end
    else if (capt_enbl)
    begin
      target_q <= target_staged;  // staged writes after this point do not affect the move
    end
  end

  // the next position for a single step, up or down
  always_comb
  begin
    if (up1_dwn0)
    begin
      step_pos = position + 1'b1;
    end
    else
    begin
      step_pos = position - 1'b1;
    end
  end

  // up/down position counter
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      position <= '0;
    end
    else if (init)
    begin
      position <= '0;  // home position is the origin
    end
    else if (count_en)
    begin
      position <= step_pos;  // one unit per enabled cycle
    end
  end

  // magnitude comparator, exactly one of the three flags is high at any time
  always_comb
  begin
    comp_eq = (position == target_q);
    comp_gt = (position > target_q);  // the axis has to count down
    comp_lt = (position < target_q);  // the axis has to count up
  end

endmodule

`default_nettype wire

//--- verilog/motion_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

// Mealy FSM that runs the initialize, capture, move and complete cycle
// the step enables in in_motion come straight from the axis comparators
module motion_sequencer (
  input  wire  clk,
  input  wire  reset,
  input  wire  motion,      // one-cycle request from the register block
  input  wire  x_comp_eq,
  input  wire  x_comp_gt,
  input  wire  x_comp_lt,
  input  wire  y_comp_eq,
  input  wire  y_comp_gt,
  input  wire  y_comp_lt,
  output logic init,        // clears both axis channels
  output logic x_count_en,
  output logic x_up1_dwn0,
  output logic y_count_en,
  output logic y_up1_dwn0,
  output logic capt_enbl,   // latches the staged targets into both axes
  output logic busy,        // high in every state except at_rest
  output logic done_pulse   // one cycle at the end of each move
);

  xy_motion_pkg::seq_state_t state;       // registered state
  xy_motion_pkg::seq_state_t next_state;  // decoded next state

  // state register
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state <= xy_motion_pkg::initialize1;  // restart the cycle from the clearing state
    end
    else
    begin
      state <= next_state;
    end
  end

  // next-state logic
  always_comb
  begin
    next_state = state;  // hold unless a transition below fires
    case (state)
      xy_motion_pkg::initialize1:
      begin
        next_state = xy_motion_pkg::initialize2;
      end
      xy_motion_pkg::initialize2:
      begin
        next_state = xy_motion_pkg::at_rest;
      end
      xy_motion_pkg::at_rest:
      begin
        if (motion)
        begin
          next_state = xy_motion_pkg::capture_xy;  // a go command was accepted
        end
      end
      xy_motion_pkg::capture_xy:
      begin
        if (!motion)
        begin
          next_state = xy_motion_pkg::in_motion;  // wait for the request to drop
        end
      end
      xy_motion_pkg::in_motion:
      begin
        if (x_comp_eq && y_comp_eq)
        begin
          next_state = xy_motion_pkg::xy_reached;  // both axes sit on their targets
        end
      end
      xy_motion_pkg::xy_reached:
      begin
        next_state = xy_motion_pkg::at_rest;
      end
      default:
      begin
        next_state = xy_motion_pkg::at_rest;  // unused encodings fall back to idle
      end
    endcase
  end

  // output decode, all outputs are low unless the state drives them
  always_comb
  begin
    init       = 1'b0;
    x_count_en = 1'b0;
    x_up1_dwn0 = 1'b0;
    y_count_en = 1'b0;
    y_up1_dwn0 = 1'b0;
    capt_enbl  = 1'b0;
    done_pulse = 1'b0;
    busy       = (state != xy_motion_pkg::at_rest);  // initialization counts as busy too
    case (state)
      xy_motion_pkg::initialize1:
      begin
        init = 1'b1;  // counters and captured targets go to zero
      end
      xy_motion_pkg::capture_xy:
      begin
        capt_enbl = 1'b1;  // latched at the end of this cycle
      end
      xy_motion_pkg::in_motion:
      begin
        x_count_en = x_comp_gt || x_comp_lt;  // step while x is off target
        x_up1_dwn0 = x_comp_lt;               // below target means count up
        y_count_en = y_comp_gt || y_comp_lt;
        y_up1_dwn0 = y_comp_lt;
      end
      xy_motion_pkg::xy_reached:
      begin
        done_pulse = 1'b1;  // sets the sticky done bit in the register block
      end
      default:
      begin
        init = 1'b0;  // initialize2 and at_rest drive nothing
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/xy_host_regs.sv
`timescale 1ns/1ps
`default_nettype none

// AXI4-Lite slave with the staged targets, the go pulse and the readback
// a write is taken when address and data are both valid and no response is pending
module xy_host_regs #(
  parameter int COORD_WIDTH = 10  // bits in one coordinate
) (
  input  wire                                     clk,
  input  wire                                     reset,
  input  wire [xy_motion_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
  input  wire                                     awvalid,
  output logic                                    awready,
  input  wire [xy_motion_pkg::AXI_DATA_WIDTH-1:0] wdata,
  input  wire                                     wvalid,
  output logic                                    wready,
  output xy_motion_pkg::axi_resp_t                bresp,
  output logic                                    bvalid,
  input  wire                                     bready,
  input  wire [xy_motion_pkg::AXI_ADDR_WIDTH-1:0] araddr,
  input  wire                                     arvalid,
  output logic                                    arready,
  output logic [xy_motion_pkg::AXI_DATA_WIDTH-1:0] rdata,
  output xy_motion_pkg::axi_resp_t                rresp,
  output logic                                    rvalid,
  input  wire                                     rready,
  input  wire                                     busy,        // sequencer is not at rest
  input  wire                                     done_pulse,  // sequencer finished a move
  input  wire [COORD_WIDTH-1:0]                   pos_x,
  input  wire [COORD_WIDTH-1:0]                   pos_y,
  output logic                                    motion,      // one-cycle go request
  output logic [COORD_WIDTH-1:0]                  target_x_staged,
  output logic [COORD_WIDTH-1:0]                  target_y_staged
);

  logic wr_fire;    // write accepted this cycle
  logic rd_fire;    // read accepted this cycle
  logic busy_any;   // a move is pending or running
  logic wr_err;     // the write in flight is refused
  logic go_ok;      // accepted go command
  logic done_q;     // sticky done bit
  logic [15:0] pos_x_ext;  // positions widened to their readback fields
  logic [15:0] pos_y_ext;
  logic [xy_motion_pkg::AXI_DATA_WIDTH-1:0] tgt_x_word;  // staged targets widened to a word
  logic [xy_motion_pkg::AXI_DATA_WIDTH-1:0] tgt_y_word;
  logic [xy_motion_pkg::AXI_DATA_WIDTH-1:0] rd_word;     // read data before the output register
  xy_motion_pkg::axi_resp_t wr_resp;
  xy_motion_pkg::axi_resp_t rd_resp;

  assign awready  = !bvalid;  // address and data are taken together
  assign wready   = !bvalid;
  assign arready  = !rvalid;  // one read outstanding at most
  assign wr_fire  = awvalid && wvalid && awready && wready;
  assign rd_fire  = arvalid && arready;
  assign busy_any = busy || motion;  // covers the cycle before the sequencer leaves at_rest
  assign go_ok    = wr_fire && !wr_err && (awaddr == xy_motion_pkg::ADDR_CTRL) && wdata[0];
  assign wr_resp  = wr_err ? xy_motion_pkg::slverr : xy_motion_pkg::okay;

  // write decode, read-only and unmapped offsets are refused
  always_comb
  begin
    case (awaddr)
      xy_motion_pkg::ADDR_CTRL:     wr_err = wdata[0] && busy_any;  // no go while a move runs
      xy_motion_pkg::ADDR_TARGET_X: wr_err = 1'b0;
      xy_motion_pkg::ADDR_TARGET_Y: wr_err = 1'b0;
      default:                      wr_err = 1'b1;  // POS, STATUS and holes in the map
    endcase
  end

  // zero-extend the coordinates into their readback fields
  always_comb
  begin
    pos_x_ext  = '0;
    pos_y_ext  = '0;
    tgt_x_word = '0;
    tgt_y_word = '0;
    pos_x_ext[COORD_WIDTH-1:0]  = pos_x;
    pos_y_ext[COORD_WIDTH-1:0]  = pos_y;
    tgt_x_word[COORD_WIDTH-1:0] = target_x_staged;
    tgt_y_word[COORD_WIDTH-1:0] = target_y_staged;
  end

  // read mux, CTRL always reads back as zero
  always_comb
  begin
    rd_word = '0;
    rd_resp = xy_motion_pkg::okay;
    case (araddr)
      xy_motion_pkg::ADDR_CTRL:     rd_word = '0;
      xy_motion_pkg::ADDR_TARGET_X: rd_word = tgt_x_word;
      xy_motion_pkg::ADDR_TARGET_Y: rd_word = tgt_y_word;
      xy_motion_pkg::ADDR_POS:      rd_word = {pos_y_ext, pos_x_ext};
      xy_motion_pkg::ADDR_STATUS:   rd_word[1:0] = {done_q, busy_any};
      default:                      rd_resp = xy_motion_pkg::slverr;  // unmapped offset
    endcase
  end

  // handshake state, staged targets, go pulse and done bit
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      bvalid          <= 1'b0;
      rvalid          <= 1'b0;
      motion          <= 1'b0;
      done_q          <= 1'b0;
      target_x_staged <= '0;
      target_y_staged <= '0;
    end
    else
    begin
      motion <= go_ok;  // high exactly in the cycle after the accepted go write
      if (wr_fire)
      begin
        bvalid <= 1'b1;  // response follows on the next cycle
      end
      else if (bready)
      begin
        bvalid <= 1'b0;  // held until the host takes it
      end
      if (rd_fire)
      begin
        rvalid <= 1'b1;
      end
      else if (rready)
      begin
        rvalid <= 1'b0;
      end
      if (wr_fire && !wr_err && (awaddr == xy_motion_pkg::ADDR_TARGET_X))
      begin
        target_x_staged <= wdata[COORD_WIDTH-1:0];  // byte enables are ignored
      end
      if (wr_fire && !wr_err && (awaddr == xy_motion_pkg::ADDR_TARGET_Y))
      begin
        target_y_staged <= wdata[COORD_WIDTH-1:0];
      end
      if (go_ok)
      begin
        done_q <= 1'b0;  // a new move clears the previous completion
      end
      else if (done_pulse)
      begin
        done_q <= 1'b1;
      end
    end
  end

  // response payloads, loaded on acceptance and stable while valid is high
  always_ff @(posedge clk)
  begin
    if (wr_fire)
    begin
      bresp <= wr_resp;
    end
    if (rd_fire)
    begin
      rdata <= rd_word;
      rresp <= rd_resp;
    end
  end

endmodule

`default_nettype wire

//--- verilog/xy_motion_top.sv
`timescale 1ns/1ps
`default_nettype none

// x/y positioning controller with an AXI4-Lite host port
// two axis channels run side by side under one sequencer
module xy_motion_top #(
  parameter int COORD_WIDTH = 10  // bits per coordinate, 2 to 16
) (
  input  wire                                     clk,
  input  wire                                     reset,
  input  wire [xy_motion_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
  input  wire                                     awvalid,
  output logic                                    awready,
  input  wire [xy_motion_pkg::AXI_DATA_WIDTH-1:0] wdata,
  input  wire                                     wvalid,
  output logic                                    wready,
  output xy_motion_pkg::axi_resp_t                bresp,
  output logic                                    bvalid,
  input  wire                                     bready,
  input  wire [xy_motion_pkg::AXI_ADDR_WIDTH-1:0] araddr,
  input  wire                                     arvalid,
  output logic                                    arready,
  output logic [xy_motion_pkg::AXI_DATA_WIDTH-1:0] rdata,
  output xy_motion_pkg::axi_resp_t                rresp,
  output logic                                    rvalid,
  input  wire                                     rready
);

  logic                   motion;       // go request into the sequencer
  logic [COORD_WIDTH-1:0] target_x_staged;
  logic [COORD_WIDTH-1:0] target_y_staged;
  logic                   init;         // shared clear for both axes
  logic                   capt_enbl;    // shared capture for both axes
  logic                   x_count_en;
  logic                   x_up1_dwn0;
  logic                   y_count_en;
  logic                   y_up1_dwn0;
  logic                   busy;
  logic                   done_pulse;
  logic                   x_comp_eq;
  logic                   x_comp_gt;
  logic                   x_comp_lt;
  logic                   y_comp_eq;
  logic                   y_comp_gt;
  logic                   y_comp_lt;
  logic [COORD_WIDTH-1:0] pos_x;
  logic [COORD_WIDTH-1:0] pos_y;

  // host register block
  xy_host_regs #(
    .COORD_WIDTH(COORD_WIDTH)
  ) u_regs (
    .clk(clk),
    .reset(reset),
    .awaddr(awaddr),
    .awvalid(awvalid),
    .awready(awready),
    .wdata(wdata),
    .wvalid(wvalid),
    .wready(wready),
    .bresp(bresp),
    .bvalid(bvalid),
    .bready(bready),
    .araddr(araddr),
    .arvalid(arvalid),
    .arready(arready),
    .rdata(rdata),
    .rresp(rresp),
    .rvalid(rvalid),
    .rready(rready),
    .busy(busy),
    .done_pulse(done_pulse),
    .pos_x(pos_x),
    .pos_y(pos_y),
    .motion(motion),
    .target_x_staged(target_x_staged),
    .target_y_staged(target_y_staged)
  );

  // x axis
  axis_channel #(
    .COORD_WIDTH(COORD_WIDTH)
  ) u_axis_x (
    .clk(clk),
    .reset(reset),
    .init(init),
    .capt_enbl(capt_enbl),
    .count_en(x_count_en),
    .up1_dwn0(x_up1_dwn0),
    .target_staged(target_x_staged),
    .position(pos_x),
    .comp_eq(x_comp_eq),
    .comp_gt(x_comp_gt),
    .comp_lt(x_comp_lt)
  );

  // y axis, same channel with its own enable and direction
  axis_channel #(
    .COORD_WIDTH(COORD_WIDTH)
  ) u_axis_y (
    .clk(clk),
    .reset(reset),
    .init(init),
    .capt_enbl(capt_enbl),
    .count_en(y_count_en),
    .up1_dwn0(y_up1_dwn0),
    .target_staged(target_y_staged),
    .position(pos_y),
    .comp_eq(y_comp_eq),
    .comp_gt(y_comp_gt),
    .comp_lt(y_comp_lt)
  );

  // sequencer combines both comparator sets into one decision
  motion_sequencer u_seq (
    .clk(clk),
    .reset(reset),
    .motion(motion),
    .x_comp_eq(x_comp_eq),
    .x_comp_gt(x_comp_gt),
    .x_comp_lt(x_comp_lt),
    .y_comp_eq(y_comp_eq),
    .y_comp_gt(y_comp_gt),
    .y_comp_lt(y_comp_lt),
    .init(init),
    .x_count_en(x_count_en),
    .x_up1_dwn0(x_up1_dwn0),
    .y_count_en(y_count_en),
    .y_up1_dwn0(y_up1_dwn0),
    .capt_enbl(capt_enbl),
    .busy(busy),
    .done_pulse(done_pulse)
  );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// clock and reset source for the testbench
module tb_clock_gen #(
  parameter int PERIOD_NS    = 4,  // full clock period
  parameter int RESET_CYCLES = 2   // rising edges seen with reset high
) (
  output logic clk,
  output logic reset
);

  initial
  begin
    clk   = 1'b0;
    reset = 1'b1;  // asserted from time zero
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;  // released on a rising edge like every other DUT input
  end

  always #(PERIOD_NS / 2) clk = ~clk;  // toggles every half period

endmodule

`default_nettype wire

//--- testbench/tb_xy_motion.sv
`timescale 1ns/1ps
`default_nettype none

// directed tests of the x/y positioning controller through its AXI4-Lite port
module tb_xy_motion;

  localparam int COORD_WIDTH     = 10;
  localparam int FULL_RANGE      = 1 << COORD_WIDTH;
  localparam int DONE_LIMIT      = 2 * FULL_RANGE + 20;      // longest move with margin
  localparam int CLK_PERIOD      = 4;
  localparam int MOVE_CYCLES     = FULL_RANGE + 226;         // longest move plus bus overhead
  localparam int WATCHDOG_NS     = 20 * MOVE_CYCLES * CLK_PERIOD;  // 20 of the longest moves take 100 us
  localparam int HANDSHAKE_LIMIT = 20;                       // cycles to wait for a ready or valid

  logic clk;
  logic reset;
  logic [xy_motion_pkg::AXI_ADDR_WIDTH-1:0] awaddr;
  logic awvalid;
  logic awready;
  logic [xy_motion_pkg::AXI_DATA_WIDTH-1:0] wdata;
  logic wvalid;
  logic wready;
  xy_motion_pkg::axi_resp_t bresp;
  logic bvalid;
  logic bready;
  logic [xy_motion_pkg::AXI_ADDR_WIDTH-1:0] araddr;
  logic arvalid;
  logic arready;
  logic [xy_motion_pkg::AXI_DATA_WIDTH-1:0] rdata;
  xy_motion_pkg::axi_resp_t rresp;
  logic rvalid;
  logic rready;

  int errors;
  int checks;
  int cycle_count = 0;            // free-running count of rising edges
  integer seed;
  logic [COORD_WIDTH-1:0] exp_x;  // model of the position as the last target reached
  logic [COORD_WIDTH-1:0] exp_y;
  logic [COORD_WIDTH-1:0] stg_x;  // model of the staged target registers
  logic [COORD_WIDTH-1:0] stg_y;
  logic [COORD_WIDTH-1:0] tgt_x;  // targets captured by the move that is running
  logic [COORD_WIDTH-1:0] tgt_y;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(2)) u_clk (.clk(clk), .reset(reset));

  xy_motion_top #(
    .COORD_WIDTH(COORD_WIDTH)
  ) u_dut (
    .clk(clk), .reset(reset),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
  );

  always @(posedge clk) cycle_count <= cycle_count + 1;

  // POS register layout with y in the upper half and x in the lower half
  function automatic logic [31:0] pos_word(input logic [COORD_WIDTH-1:0] x,
                                           input logic [COORD_WIDTH-1:0] y);
    pos_word = {{(16-COORD_WIDTH){1'b0}}, y, {(16-COORD_WIDTH){1'b0}}, x};
  endfunction

  task automatic compare_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_resp(input string what, input xy_motion_pkg::axi_resp_t got,
                              input xy_motion_pkg::axi_resp_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Error at %0t ns: %s answered %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  // one write with bready held low for stall cycles once bvalid is seen
  task automatic axi_write(input logic [xy_motion_pkg::AXI_ADDR_WIDTH-1:0] addr,
                           input logic [xy_motion_pkg::AXI_DATA_WIDTH-1:0] data,
                           input int stall, output xy_motion_pkg::axi_resp_t resp);
    int wait_cycles;
    xy_motion_pkg::axi_resp_t held;
    wait_cycles = 0;
    @(posedge clk);
    awaddr  <= addr;
    wdata   <= data;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    @(negedge clk);
    while (!(awready && wready) && wait_cycles < HANDSHAKE_LIMIT)
    begin
      wait_cycles++;
      @(negedge clk);
    end
    @(posedge clk);  // address and data are taken on this edge
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(negedge clk);
    while (!bvalid && wait_cycles < HANDSHAKE_LIMIT)
    begin
      wait_cycles++;
      @(negedge clk);
    end
    if (wait_cycles >= HANDSHAKE_LIMIT)
    begin
      errors++;
      $display("write to offset %h did not complete its handshake in %0d cycles", addr,
               HANDSHAKE_LIMIT);
    end
    held = bresp;
    repeat (stall)
    begin
      @(negedge clk);
      checks++;
      if (!bvalid || bresp !== held || awready || wready)  // no new write while one is pending
      begin
        errors++;
        $display("Error at %0t ns: write response to %h not held or a new write taken",
                 $time, addr);
      end
    end
    @(posedge clk);
    bready <= 1'b1;
    @(posedge clk);
    bready <= 1'b0;  // the response is taken on this edge
    resp = held;
  endtask

  // one read with rready held low for stall cycles once rvalid is seen
  task automatic axi_read(input logic [xy_motion_pkg::AXI_ADDR_WIDTH-1:0] addr, input int stall,
                          output logic [31:0] data, output xy_motion_pkg::axi_resp_t resp);
    int wait_cycles;
    wait_cycles = 0;
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    @(negedge clk);
    while (!arready && wait_cycles < HANDSHAKE_LIMIT)
    begin
      wait_cycles++;
      @(negedge clk);
    end
    @(posedge clk);
    arvalid <= 1'b0;
    @(negedge clk);
    while (!rvalid && wait_cycles < HANDSHAKE_LIMIT)
    begin
      wait_cycles++;
      @(negedge clk);
    end
    if (wait_cycles >= HANDSHAKE_LIMIT)
    begin
      errors++;
      $display("read of offset %h did not complete its handshake in %0d cycles", addr,
               HANDSHAKE_LIMIT);
    end
    data = rdata;
    resp = rresp;
    repeat (stall)
    begin
      @(negedge clk);
      checks++;
      if (!rvalid || rdata !== data || rresp !== resp || arready)  // one read outstanding
      begin
        errors++;
        $display("Error at %0t ns: read data of %h not held or a new read taken",
                 $time, addr);
      end
    end
    @(posedge clk);
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  // reads STATUS until the done bit is set or the longest possible move has passed
  task automatic poll_done(output logic [31:0] status);
    int start;
    logic [31:0] word;
    xy_motion_pkg::axi_resp_t resp;
    start = cycle_count;
    word  = '0;
    while (!word[1] && (cycle_count - start) < DONE_LIMIT)
    begin
      axi_read(xy_motion_pkg::ADDR_STATUS, 0, word, resp);
    end
    if (!word[1])
    begin
      errors++;
      $display("done bit not set within %0d cycles, sequencer stuck in %s", DONE_LIMIT,
               u_dut.u_seq.state.name());
    end
    status = word;
  endtask

  // compares every readable register with the model and STATUS with the caller's value
  task automatic verify_registers(input logic [31:0] status_exp);
    logic [31:0] word;
    xy_motion_pkg::axi_resp_t resp;
    axi_read(xy_motion_pkg::ADDR_CTRL, 0, word, resp);
    compare_word("CTRL", word, 32'h0);
    compare_resp("CTRL read", resp, xy_motion_pkg::okay);
    axi_read(xy_motion_pkg::ADDR_TARGET_X, 0, word, resp);
    compare_word("TARGET_X", word, 32'(stg_x));
    compare_resp("TARGET_X read", resp, xy_motion_pkg::okay);
    axi_read(xy_motion_pkg::ADDR_TARGET_Y, 0, word, resp);
    compare_word("TARGET_Y", word, 32'(stg_y));
    compare_resp("TARGET_Y read", resp, xy_motion_pkg::okay);
    axi_read(xy_motion_pkg::ADDR_POS, 0, word, resp);
    compare_word("POS", word, pos_word(exp_x, exp_y));
    compare_resp("POS read", resp, xy_motion_pkg::okay);
    axi_read(xy_motion_pkg::ADDR_STATUS, 0, word, resp);
    compare_word("STATUS", word, status_exp);
    compare_resp("STATUS read", resp, xy_motion_pkg::okay);
  endtask

  // stages both targets and issues the go command
  task automatic start_move(input logic [COORD_WIDTH-1:0] tx, input logic [COORD_WIDTH-1:0] ty);
    logic [31:0] word;
    xy_motion_pkg::axi_resp_t resp;
    int dist_x;
    int dist_y;
    axi_write(xy_motion_pkg::ADDR_TARGET_X, 32'(tx), 0, resp);
    compare_resp("TARGET_X write", resp, xy_motion_pkg::okay);
    axi_write(xy_motion_pkg::ADDR_TARGET_Y, 32'(ty), 0, resp);
    compare_resp("TARGET_Y write", resp, xy_motion_pkg::okay);
    stg_x  = tx;
    stg_y  = ty;
    tgt_x  = tx;  // these are the targets the go captures
    tgt_y  = ty;
    dist_x = (tx > exp_x) ? tx - exp_x : exp_x - tx;
    dist_y = (ty > exp_y) ? ty - exp_y : exp_y - ty;
    axi_write(xy_motion_pkg::ADDR_CTRL, 32'h1, 0, resp);
    compare_resp("go write", resp, xy_motion_pkg::okay);
    if (dist_x > 8 || dist_y > 8)
    begin
      axi_read(xy_motion_pkg::ADDR_STATUS, 0, word, resp);
      compare_word("STATUS during move", word, 32'h1);  // busy is set and the go has cleared done
    end
  endtask

  // waits for done and checks that the position landed on the captured targets
  task automatic finish_move();
    logic [31:0] word;
    xy_motion_pkg::axi_resp_t resp;
    poll_done(word);
    compare_word("STATUS after move", word, 32'h2);
    exp_x = tgt_x;
    exp_y = tgt_y;
    axi_read(xy_motion_pkg::ADDR_POS, 0, word, resp);
    compare_word("POS after move", word, pos_word(exp_x, exp_y));
  endtask

  task automatic move_to(input logic [COORD_WIDTH-1:0] tx, input logic [COORD_WIDTH-1:0] ty);
    start_move(tx, ty);
    finish_move();
  endtask

  task automatic reset_values();
    verify_registers(32'h0);  // idle with nothing done yet and both counters at the origin
  endtask

  task automatic two_moves();
    move_to(10'd300, 10'd45);
    move_to(10'd12, 10'd700);  // x counts down while y counts up over a longer distance
  endtask

  task automatic go_while_busy();
    xy_motion_pkg::axi_resp_t resp;
    start_move(10'd500, 10'd100);
    axi_write(xy_motion_pkg::ADDR_CTRL, 32'h1, 0, resp);
    compare_resp("go while busy", resp, xy_motion_pkg::slverr);
    axi_write(xy_motion_pkg::ADDR_TARGET_X, 32'd7, 0, resp);
    compare_resp("TARGET_X write during move", resp, xy_motion_pkg::okay);
    stg_x = 10'd7;
    axi_write(xy_motion_pkg::ADDR_TARGET_Y, 32'd900, 0, resp);
    compare_resp("TARGET_Y write during move", resp, xy_motion_pkg::okay);
    stg_y = 10'd900;
    finish_move();  // still ends on the first pair
    verify_registers(32'h2);
  endtask

  task automatic illegal_access();
    logic [31:0] word;
    xy_motion_pkg::axi_resp_t resp;
    axi_write(5'h14, 32'hffff_ffff, 0, resp);
    compare_resp("write to unmapped 0x14", resp, xy_motion_pkg::slverr);
    axi_read(5'h14, 0, word, resp);
    compare_resp("read of unmapped 0x14", resp, xy_motion_pkg::slverr);
    axi_read(5'h1c, 0, word, resp);
    compare_resp("read of unmapped 0x1c", resp, xy_motion_pkg::slverr);
    axi_write(xy_motion_pkg::ADDR_POS, 32'h1234_5678, 0, resp);
    compare_resp("write to POS", resp, xy_motion_pkg::slverr);
    axi_write(xy_motion_pkg::ADDR_STATUS, 32'h3, 0, resp);
    compare_resp("write to STATUS", resp, xy_motion_pkg::slverr);
    verify_registers(32'h2);
  endtask

  task automatic backpressure();
    logic [31:0] word;
    xy_motion_pkg::axi_resp_t resp;
    start_move(10'd900, 10'd3);
    axi_write(xy_motion_pkg::ADDR_TARGET_Y, 32'd40, 5, resp);
    compare_resp("stalled TARGET_Y write", resp, xy_motion_pkg::okay);
    stg_y = 10'd40;
    axi_read(xy_motion_pkg::ADDR_POS, 5, word, resp);
    compare_resp("stalled POS read", resp, xy_motion_pkg::okay);
    axi_read(5'h18, 4, word, resp);
    compare_resp("stalled unmapped read", resp, xy_motion_pkg::slverr);
    finish_move();
  endtask

  task automatic random_moves();
    logic [31:0] rnd;
    logic [COORD_WIDTH-1:0] tx;
    logic [COORD_WIDTH-1:0] ty;
    for (int i = 0; i < 8; i++)
    begin
      if (i == 3)
      begin
        tx = exp_x;  // a zero-length move still spends one cycle in in_motion
        ty = exp_y;
      end
      else
      begin
        rnd = $random(seed);
        tx  = rnd[COORD_WIDTH-1:0];
        rnd = $random(seed);
        ty  = rnd[COORD_WIDTH-1:0];
      end
      move_to(tx, ty);
    end
  endtask

  initial
  begin
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    errors  = 0;
    checks  = 0;
    seed    = 32'h554b730c;
    exp_x   = '0;
    exp_y   = '0;
    stg_x   = '0;
    stg_y   = '0;
    tgt_x   = '0;
    tgt_y   = '0;
    wait (reset === 1'b0);
    repeat (4) @(posedge clk);  // lets initialize1 and initialize2 run to at_rest
    reset_values();
    two_moves();
    go_while_busy();
    illegal_access();
    backpressure();
    random_moves();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- xy_motion_top.f
verilog/xy_motion_pkg.sv
verilog/axis_channel.sv
verilog/motion_sequencer.sv
verilog/xy_host_regs.sv
verilog/xy_motion_top.sv
testbench/tb_clock_gen.sv
testbench/tb_xy_motion.sv

//--- Bender.yml
package:
  name: xy_motion

sources:
  # RTL in compile order, package first
  - verilog/xy_motion_pkg.sv
  - verilog/axis_channel.sv
  - verilog/motion_sequencer.sv
  - verilog/xy_host_regs.sv
  - verilog/xy_motion_top.sv

  # testbench, top module tb_xy_motion
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_xy_motion.sv
